//--- build.f
verilog/clint_pkg.sv
verilog/axil_slave_port.sv
verilog/clint_timer.sv
verilog/clint_top.sv
tests/clint_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the CLINT testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module clint_tb -f build.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vclint_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/clint_tb.sv
`timescale 1ns/1ps

module clint_tb;

    // about four times the summed length of all tests
    localparam int TIMEOUT_CYCLES = 2000;

    logic                 clk;
    logic                 rst_n;
    clint_pkg::axil_req_t req;
    clint_pkg::axil_rsp_t rsp;
    logic                 timer_irq;
    logic                 soft_irq;
    logic [31:0]          lfsr = 32'he385_73ed;
    int                   cycle = 0;
    int                   irq_cnt = 0;
    int                   wr_edge;
    int                   rd_edge;

    clint_top #(.TICK_DIV(4)) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (req),
        .bus_rsp   (rsp),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    // cycle count for the watchdog and a count of timer pulses
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (rst_n && timer_irq)
            irq_cnt = irq_cnt + 1;
        if (cycle >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
    end

    assert property (@(posedge clk) disable iff (!rst_n) rsp.awready == rsp.wready)
        else stop_on_error("awready and wready were not high together");
    assert property (@(posedge clk) disable iff (!rst_n) rsp.awready |=> !rsp.awready)
        else stop_on_error("awready was high for more than one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) rsp.arready |=> !rsp.arready)
        else stop_on_error("arready was high for more than one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) rsp.bvalid && !req.bready |=> rsp.bvalid)
        else stop_on_error("bvalid dropped before bready");
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
        else stop_on_error("rvalid or rdata changed before rready");
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp.bvalid |-> rsp.bresp == clint_pkg::RESP_OKAY)
        else stop_on_error("bresp was not OKAY");
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp.rvalid |-> rsp.rresp == clint_pkg::RESP_OKAY)
        else stop_on_error("rresp was not OKAY");
    assert property (@(posedge clk) disable iff (!rst_n) timer_irq |=> !timer_irq)
        else stop_on_error("timer_irq was high for more than one cycle");

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (got == exp)
            else stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, got));
    endtask

    task automatic check_range(input string name, input logic [63:0] lo,
                               input logic [63:0] hi, input logic [63:0] got);
        assert (got >= lo && got <= hi)
            else stop_on_error($sformatf("MISMATCH %s expected %h..%h actual %h",
                                         name, lo, hi, got));
    endtask

    task automatic check_idle(input string when);
        assert (!rsp.awready && !rsp.wready && !rsp.arready && !rsp.bvalid && !rsp.rvalid
                && !timer_irq && !soft_irq)
            else stop_on_error({"an output was not low ", when});
    endtask

    task automatic send_write(input logic [15:0] ofs, input logic [63:0] data,
                              input logic [7:0] strb);
        @(posedge clk);
        #1;
        req.awaddr  = {48'd0, ofs};
        req.wdata   = data;
        req.wstrb   = strb;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
    endtask

    // the B handshake is left open while bready is held low
    task automatic finish_write();
        while (!rsp.awready)
            @(negedge clk);
        wr_edge = cycle;
        @(posedge clk);
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        while (!rsp.bvalid)
            @(negedge clk);
        if (req.bready)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic axil_write(input logic [15:0] ofs, input logic [63:0] data,
                              input logic [7:0] strb);
        send_write(ofs, data, strb);
        finish_write();
    endtask

    task automatic axil_read(input logic [15:0] ofs, output logic [63:0] data);
        @(posedge clk);
        #1;
        req.araddr  = {48'd0, ofs};
        req.arvalid = 1'b1;
        while (!rsp.arready)
            @(negedge clk);
        rd_edge = cycle;
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        while (!rsp.rvalid)
            @(negedge clk);
        data = rsp.rdata;
        // a held rready stalls the R channel for three cycles
        if (!req.rready)
        begin
            repeat (3) @(posedge clk);
            #1;
            req.rready = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        logic [63:0] a, b, mask, v1, v2, w, cmp, mt;
        logic [7:0]  s;
        int          n0;
        int          c;
        int          t0;
        req        = '0;
        req.bready = 1'b1;
        req.rready = 1'b1;
        rst_n      = 1'b0;
        repeat (8)
        begin
            @(posedge clk);
            #1;
            check_idle("during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");

        // mtimecmp with random strobes
        a = rand_bits(64);
        axil_write(clint_pkg::MTIMECMP_OFS, a, 8'hff);
        b = rand_bits(64);
        s = 8'(rand_bits(8));
        axil_write(clint_pkg::MTIMECMP_OFS, b, s);
        for (int i = 0; i < 8; i++)
            mask[i*8 +: 8] = {8{s[i]}};
        axil_read(clint_pkg::MTIMECMP_OFS, v1);
        check_eq("mtimecmp strobes", (b & mask) | (a & ~mask), v1);

        // mtime advances once per four clocks
        w = {1'b0, 63'(rand_bits(63))};
        axil_write(clint_pkg::MTIME_OFS, w, 8'hff);
        axil_read(clint_pkg::MTIME_OFS, v1);
        c = rd_edge - wr_edge;
        check_range("mtime count", w, w + 64'(c / 4 + 1), v1);
        repeat (4) @(posedge clk);
        axil_read(clint_pkg::MTIME_OFS, v2);
        check_range("mtime second read", v1 + 64'd1, '1, v2);

        // timer interrupt
        axil_write(clint_pkg::MTIMECMP_OFS, '1, 8'hff);
        repeat (3) @(negedge clk);
        n0 = irq_cnt;
        repeat (30) @(negedge clk);
        check_eq("no irq below mtimecmp", 64'(n0), 64'(irq_cnt));
        cmp = v2 + 64'd20;
        axil_write(clint_pkg::MTIMECMP_OFS, cmp, 8'hff);
        c = 0;
        while (irq_cnt == n0 && c < 90)
        begin
            @(negedge clk);
            c++;
        end
        check_eq("timer irq pulse", 64'(n0 + 1), 64'(irq_cnt));
        axil_read(clint_pkg::MTIME_OFS, v1);
        check_range("mtime after irq", cmp, '1, v1);
        mt = v1;
        t0 = rd_edge;
        repeat (20) @(negedge clk);
        check_eq("no second pulse", 64'(n0 + 1), 64'(irq_cnt));
        axil_write(clint_pkg::MTIMECMP_OFS, '1, 8'hff);
        repeat (3) @(negedge clk);
        n0 = irq_cnt;
        axil_write(clint_pkg::MTIMECMP_OFS, 64'd0, 8'hff);
        repeat (5) @(negedge clk);
        check_eq("pulse after rearm", 64'(n0 + 1), 64'(irq_cnt));

        // msip level and its strobe
        axil_write(clint_pkg::MSIP_OFS, 64'd1, 8'hff);
        check_eq("soft_irq set", 64'd1, {63'd0, soft_irq});
        axil_read(clint_pkg::MSIP_OFS, v1);
        check_eq("msip read one", 64'd1, v1);
        axil_write(clint_pkg::MSIP_OFS, 64'd0, 8'hff);
        axil_write(clint_pkg::MSIP_OFS, 64'd1, 8'hfe);
        check_eq("soft_irq clear", 64'd0, {63'd0, soft_irq});
        axil_read(clint_pkg::MSIP_OFS, v1);
        check_eq("msip read zero", 64'd0, v1);

        // unmapped offset and a stalled read of mtimecmp
        axil_read(16'h0100, v1);
        check_eq("unmapped read", 64'd0, v1);
        axil_write(16'h0100, '1, 8'hff);
        axil_read(clint_pkg::MSIP_OFS, v1);
        check_eq("msip after unmapped write", 64'd0, v1);
        axil_read(clint_pkg::MTIME_OFS, v2);
        check_range("mtime after unmapped write", mt, mt + 64'((rd_edge - t0) / 4 + 1), v2);
        req.rready = 1'b0;
        axil_read(clint_pkg::MTIMECMP_OFS, v1);
        check_eq("mtimecmp after unmapped write", 64'd0, v1);

        // second write waits behind a held B response
        req.bready = 1'b0;
        a = rand_bits(64);
        b = rand_bits(64);
        axil_write(clint_pkg::MTIMECMP_OFS, a, 8'hff);
        send_write(clint_pkg::MTIMECMP_OFS, b, 8'hff);
        repeat (6)
        begin
            @(negedge clk);
            assert (!rsp.awready && !rsp.wready && rsp.bvalid)
                else stop_on_error("a second write was accepted while bready was low");
        end
        @(posedge clk);
        #1;
        req.bready = 1'b1;
        finish_write();
        axil_read(clint_pkg::MTIMECMP_OFS, v1);
        check_eq("write after back-pressure", b, v1);

        $display("Everything OK");
        $finish;
    end

endmodule

//--- verilog/axil_slave_port.sv
`timescale 1ns/1ps

module axil_slave_port (
    input  logic                 clk,
    input  logic                 rst_n,
    input  clint_pkg::axil_req_t bus_req,
    output clint_pkg::axil_rsp_t bus_rsp,
    output clint_pkg::reg_wr_t   wr,
    output clint_pkg::reg_rd_t   rd,
    input  logic [63:0]          rd_data
);

    logic        awready_q;
    logic        wready_q;
    logic        bvalid_q;
    logic        aw_en;
    logic        arready_q;
    logic        rvalid_q;
    logic [63:0] rdata_q;

    logic wr_start;
    logic wr_hs;
    logic b_hs;
    logic rd_start;
    logic rd_hs;
    logic r_hs;

    // AW and W are accepted together once both are present
    assign wr_start = !awready_q && aw_en && !bvalid_q
                      && bus_req.awvalid && bus_req.wvalid;
    assign wr_hs    = awready_q && wready_q && bus_req.awvalid && bus_req.wvalid;
    assign b_hs     = bvalid_q && bus_req.bready;

    assign rd_start = !arready_q && !rvalid_q && bus_req.arvalid;
    assign rd_hs    = arready_q && bus_req.arvalid;
    assign r_hs     = rvalid_q && bus_req.rready;

    // write channel readies and the pending flag
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            aw_en     <= 1'b1;
        end
        else
        begin
            if (wr_start)
            begin
                awready_q <= 1'b1;
                wready_q  <= 1'b1;
                aw_en     <= 1'b0;
            end
            else
            begin
                awready_q <= 1'b0;
                wready_q  <= 1'b0;
                // pending write is retired by the B handshake
                if (b_hs)
                    aw_en <= 1'b1;
            end
        end
    end

    // write response
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            bvalid_q <= 1'b0;
        else if (wr_hs)
            bvalid_q <= 1'b1;
        else if (b_hs)
            bvalid_q <= 1'b0;
    end

    // read address ready one cycle after arvalid
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            arready_q <= 1'b0;
        else
            arready_q <= rd_start;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rvalid_q <= 1'b0;
        else if (rd_hs)
            rvalid_q <= 1'b1;
        else if (r_hs)
            rvalid_q <= 1'b0;
    end

    // read data held stable until rready
    always_ff @(posedge clk)
    begin
        if (rd_hs)
            rdata_q <= rd_data;
    end

    // register side sees only the low 16 address bits
    assign wr.en   = wr_hs;
    assign wr.ofs  = bus_req.awaddr[15:0];
    assign wr.data = bus_req.wdata;
    assign wr.strb = bus_req.wstrb;

    assign rd.en   = rd_hs;
    assign rd.ofs  = bus_req.araddr[15:0];

    always_comb
    begin
        bus_rsp.awready = awready_q;
        bus_rsp.wready  = wready_q;
        bus_rsp.bresp   = clint_pkg::RESP_OKAY;
        bus_rsp.bvalid  = bvalid_q;
        bus_rsp.arready = arready_q;
        bus_rsp.rdata   = rdata_q;
        bus_rsp.rresp   = clint_pkg::RESP_OKAY;
        bus_rsp.rvalid  = rvalid_q;
    end

endmodule

//--- verilog/clint_pkg.sv
package clint_pkg;

    // response codes, only OKAY is ever returned
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // register offsets within the CLINT window (single hart)
    localparam logic [15:0] MSIP_OFS     = 16'h0000;
    localparam logic [15:0] MTIMECMP_OFS = 16'h4000;
    localparam logic [15:0] MTIME_OFS    = 16'hbff8;

    // everything the master drives on the AXI4-Lite bus
    typedef struct packed {
        logic [63:0] awaddr;
        logic [2:0]  awprot;
        logic        awvalid;
        logic [63:0] wdata;
        logic [7:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [63:0] araddr;
        logic [2:0]  arprot;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // everything the slave drives back
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [63:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // one register write, valid for a single cycle
    typedef struct packed {
        logic        en;
        logic [15:0] ofs;
        logic [63:0] data;
        logic [7:0]  strb;
    } reg_wr_t;

    typedef struct packed {
        logic        en;
        logic [15:0] ofs;
    } reg_rd_t;

endpackage

//--- verilog/clint_timer.sv
`timescale 1ns/1ps

module clint_timer #(
    parameter int TICK_DIV = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  clint_pkg::reg_wr_t wr,
    input  clint_pkg::reg_rd_t rd,
    output logic [63:0]        rd_data,
    output logic               timer_irq,
    output logic               soft_irq
);

    // keep at least one bit so TICK_DIV of 1 still elaborates
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] presc;
    logic             tick;
    logic [63:0]      mtime;
    logic [63:0]      mtimecmp;
    logic             msip;
    logic             mtime_we;
    logic             mtimecmp_we;
    logic             msip_we;
    logic             cmp_q0;
    logic             cmp_q1;

    // byte-wise merge of new data into the old register value
    function automatic logic [63:0] merge_bytes(
        input logic [63:0] old_val,
        input logic [63:0] new_val,
        input logic [7:0]  strb
    );
        logic [63:0] res;
        res = old_val;
        for (int i = 0; i < 8; i++)
        begin
            if (strb[i])
                res[i*8 +: 8] = new_val[i*8 +: 8];
        end
        return res;
    endfunction

    assign mtime_we    = wr.en && (wr.ofs == clint_pkg::MTIME_OFS);
    assign mtimecmp_we = wr.en && (wr.ofs == clint_pkg::MTIMECMP_OFS);
    assign msip_we     = wr.en && (wr.ofs == clint_pkg::MSIP_OFS) && wr.strb[0];

    assign tick = (presc == CNT_W'(TICK_DIV - 1));

    // prescaler, restarted by any mtime write
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            presc <= '0;
        else if (mtime_we || tick)
            presc <= '0;
        else
            presc <= presc + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            mtime <= '0;
        else if (mtime_we)
            mtime <= merge_bytes(mtime, wr.data, wr.strb);
        else if (tick)
            mtime <= mtime + 64'd1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            mtimecmp <= '0;
        else if (mtimecmp_we)
            mtimecmp <= merge_bytes(mtimecmp, wr.data, wr.strb);
    end

    // msip has a single implemented bit
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            msip <= 1'b0;
        else if (msip_we)
            msip <= wr.data[0];
    end

    // compare registered twice, pulse on the rising edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmp_q0 <= 1'b0;
            cmp_q1 <= 1'b0;
        end
        else
        begin
            cmp_q0 <= (mtime >= mtimecmp);
            cmp_q1 <= cmp_q0;
        end
    end

    assign timer_irq = cmp_q0 && !cmp_q1;
    assign soft_irq  = msip;

    always_comb
    begin
        rd_data = '0;
        if (rd.en)
        begin
            case (rd.ofs)
                clint_pkg::MSIP_OFS:     rd_data = {63'd0, msip};
                clint_pkg::MTIMECMP_OFS: rd_data = mtimecmp;
                clint_pkg::MTIME_OFS:    rd_data = mtime;
                default:                 rd_data = '0;
            endcase
        end
    end

endmodule

//--- verilog/clint_top.sv
`timescale 1ns/1ps

module clint_top #(
    parameter int TICK_DIV = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  clint_pkg::axil_req_t bus_req,
    output clint_pkg::axil_rsp_t bus_rsp,
    output logic                 timer_irq,
    output logic                 soft_irq
);

    clint_pkg::reg_wr_t wr;
    clint_pkg::reg_rd_t rd;
    logic [63:0]        rd_data;

    // bus handshake and register access strobes
    axil_slave_port port0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

    // register file, mtime counter and interrupt outputs
    clint_timer #(
        .TICK_DIV (TICK_DIV)
    ) timer0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .rd        (rd),
        .rd_data   (rd_data),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

endmodule
